// ==== mac_merge_pkg.sv ====
// shared types, delimiter codes and the mcrc fold function for the merge sublayer receive path.
package mcrc_pkg;

   // one received octet.
   typedef logic [7:0] octet_t;

   // frame count carried by smd-s and smd-c.
   typedef logic [1:0] frame_cnt_t;

   // decoded fragment count, 4 marks an invalid code.
   typedef logic [2:0] frag_cnt_t;

   // mcrc register.
   typedef logic [31:0] mcrc_t;

   // delimiter classes reported by the checker.
   typedef enum logic [2:0]
   {
      KIND_EXPRESS,
      KIND_VERIFY,
      KIND_RESPOND,
      KIND_START,
      KIND_CONT,
      KIND_ERROR
   } smd_kind_e;

   // the last four octets of a packet.
   // written as octets with the oldest in the top byte, read back as one mcrc word.
   typedef union packed
   {
      octet_t [3:0] octets;
      mcrc_t        word;
   } mcrc_tail_u;

   // start-mpacket delimiters.
   localparam octet_t SMD_E  = 8'hD5;
   localparam octet_t SMD_V  = 8'h07;
   localparam octet_t SMD_R  = 8'h19;
   localparam octet_t SMD_S0 = 8'hE6;
   localparam octet_t SMD_S1 = 8'h4C;
   localparam octet_t SMD_S2 = 8'h7F;
   localparam octet_t SMD_S3 = 8'hB3;
   localparam octet_t SMD_C0 = 8'h61;
   localparam octet_t SMD_C1 = 8'h52;
   localparam octet_t SMD_C2 = 8'h9E;
   localparam octet_t SMD_C3 = 8'h2A;

   // fragment count codes share the smd-s values.
   localparam octet_t FRAG_0 = SMD_S0;
   localparam octet_t FRAG_1 = SMD_S1;
   localparam octet_t FRAG_2 = SMD_S2;
   localparam octet_t FRAG_3 = SMD_S3;

   localparam octet_t PREAMBLE_OCTET = 8'h55;

   localparam mcrc_t MCRC_INIT = 32'hFFFF_FFFF;
   localparam mcrc_t MCRC_POLY = 32'h04C1_1DB7;
   // the transmitted mcrc differs from the crc register in the low half.
   localparam mcrc_t MCRC_XOR  = 32'h0000_FFFF;

   localparam frag_cnt_t FRAG_INVALID = 3'd4;

   // folds one octet into the mcrc, bit 0 first.
   function automatic mcrc_t mcrc_octet(input mcrc_t crc, input octet_t data);
      mcrc_t c;
      int    i;
      c = crc;
      for (i = 0; i < 8; i++)
      begin
         // feedback when the leaving bit and the data bit differ.
         if (c[31] ^ data[i])
         begin
            c = {c[30:0], 1'b0} ^ MCRC_POLY;
         end
         else
         begin
            c = {c[30:0], 1'b0};
         end
      end
      return c;
   endfunction

endpackage

// ==== octet_if.sv ====
// octet stream between the receive stages, driven through source and read through sink.
interface octet_if;

   // one-cycle pulse, octet is valid.
   logic                 strobe;

   // received octet.
   mcrc_pkg::octet_t     octet;

   // high with the first octet of a packet.
   logic                 first;

   // packet end pulse, carries no octet.
   logic                 last;

   modport source
   (
      output strobe, octet, first, last
   );

   modport sink
   (
      input strobe, octet, first, last
   );

endinterface

// ==== octet_deserializer.sv ====
// collects the serial receive bits into octets, lsb first, and marks packet start and end.
module octet_deserializer
(
   input  logic    rTXByteSent,
   input  logic    reset_begin,
   input  logic    rx_dv,
   input  logic    rx_bit,
   octet_if.source raw
);

   // partial octet, newest bit enters at the top.
   mcrc_pkg::octet_t shift;

   // bits collected so far in this octet.
   logic [2:0]       bit_cnt;

   // rx_dv one cycle back, for the falling edge.
   logic             dv_q;

   // an octet of this packet has already gone out.
   logic             in_pkt;

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         bit_cnt    <= 3'd0;
         dv_q       <= 1'b0;
         in_pkt     <= 1'b0;
         raw.strobe <= 1'b0;
         raw.first  <= 1'b0;
         raw.last   <= 1'b0;
      end
      else
      begin
         dv_q       <= rx_dv;
         raw.strobe <= 1'b0;
         raw.last   <= 1'b0;
         if (rx_dv)
         begin
            shift   <= {rx_bit, shift[7:1]};
            bit_cnt <= bit_cnt + 3'd1;
            // eighth bit, the octet leaves next cycle.
            if (bit_cnt == 3'd7)
            begin
               raw.strobe <= 1'b1;
               raw.octet  <= {rx_bit, shift[7:1]};
               raw.first  <= !in_pkt;
               in_pkt     <= 1'b1;
            end
         end
         else
         begin
            // a partial octet is dropped.
            shift   <= '0;
            bit_cnt <= 3'd0;
            in_pkt  <= 1'b0;
            // end of packet on the falling edge of rx_dv.
            raw.last <= dv_q;
         end
      end
   end

endmodule

// ==== mcrc_tail_buffer.sv ====
// four-octet delay line that keeps the mcrc field off the body stream and hands it over as tail.
module mcrc_tail_buffer
(
   input  logic                   rTXByteSent,
   input  logic                   reset_begin,
   octet_if.sink                  in_octets,
   octet_if.source                out_octets,
   output mcrc_pkg::mcrc_tail_u   tail
);

   // held octets, slot 3 is the oldest.
   mcrc_pkg::octet_t [3:0] slot;

   // packet-start flags, one per slot.
   logic [3:0]             first_q;

   // number of valid slots, 0 to 4.
   logic [2:0]             fill;

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         fill              <= 3'd0;
         first_q           <= 4'b0000;
         out_octets.strobe <= 1'b0;
         out_octets.first  <= 1'b0;
         out_octets.last   <= 1'b0;
      end
      else
      begin
         out_octets.strobe <= 1'b0;
         out_octets.last   <= 1'b0;
         if (in_octets.last)
         begin
            // whatever is held is the mcrc field.
            out_octets.last <= 1'b1;
            tail.octets     <= slot;
            fill            <= 3'd0;
            first_q         <= 4'b0000;
         end
         else if (in_octets.strobe)
         begin
            slot    <= {slot[2:0], in_octets.octet};
            first_q <= {first_q[2:0], in_octets.first};
            if (fill == 3'd4)
            begin
               // line full, the oldest octet is pushed out to the body path.
               out_octets.strobe <= 1'b1;
               out_octets.octet  <= slot[3];
               out_octets.first  <= first_q[3];
            end
            else
            begin
               fill <= fill + 3'd1;
            end
         end
      end
   end

endmodule

// ==== smd_mcrc_checker.sv ====
// hunts the preamble, decodes smd and fragment count, and checks the body mcrc against the tail.
module smd_mcrc_checker
#(
   parameter int PREAMBLE_MIN = 3
)
(
   input  logic                   rTXByteSent,
   input  logic                   reset_begin,
   octet_if.sink                  body,
   input  mcrc_pkg::mcrc_tail_u   tail,
   output logic                   smd_valid,
   output mcrc_pkg::smd_kind_e    smd_kind,
   output mcrc_pkg::frame_cnt_t   frame_cnt,
   output logic                   frag_valid,
   output mcrc_pkg::frag_cnt_t    frag_cnt,
   output logic                   check_done,
   output logic                   mcrc_ok
);

   localparam int CNT_W = $clog2(PREAMBLE_MIN + 1);

   // fsm states.
   localparam logic [1:0] ST_HUNT = 2'd0;
   localparam logic [1:0] ST_SMD  = 2'd1;
   localparam logic [1:0] ST_FRAG = 2'd2;
   localparam logic [1:0] ST_BODY = 2'd3;

   logic [1:0]           state;
   logic [CNT_W-1:0]     pre_cnt;
   // short preamble seen, ignore the rest of this packet.
   logic                 skip;
   mcrc_pkg::mcrc_t      mcrc;
   mcrc_pkg::smd_kind_e  dec_kind;
   mcrc_pkg::frame_cnt_t dec_frame;
   mcrc_pkg::frag_cnt_t  dec_frag;

   // delimiter class and frame count of the current octet.
   always_comb
   begin
      case (body.octet)
         mcrc_pkg::SMD_E: dec_kind = mcrc_pkg::KIND_EXPRESS;
         mcrc_pkg::SMD_V: dec_kind = mcrc_pkg::KIND_VERIFY;
         mcrc_pkg::SMD_R: dec_kind = mcrc_pkg::KIND_RESPOND;
         mcrc_pkg::SMD_S0, mcrc_pkg::SMD_S1,
         mcrc_pkg::SMD_S2, mcrc_pkg::SMD_S3: dec_kind = mcrc_pkg::KIND_START;
         mcrc_pkg::SMD_C0, mcrc_pkg::SMD_C1,
         mcrc_pkg::SMD_C2, mcrc_pkg::SMD_C3: dec_kind = mcrc_pkg::KIND_CONT;
         default: dec_kind = mcrc_pkg::KIND_ERROR;
      endcase
      case (body.octet)
         mcrc_pkg::SMD_S1, mcrc_pkg::SMD_C1: dec_frame = 2'd1;
         mcrc_pkg::SMD_S2, mcrc_pkg::SMD_C2: dec_frame = 2'd2;
         mcrc_pkg::SMD_S3, mcrc_pkg::SMD_C3: dec_frame = 2'd3;
         default: dec_frame = 2'd0;
      endcase
      // fragment count, unknown codes give 4.
      case (body.octet)
         mcrc_pkg::FRAG_0: dec_frag = 3'd0;
         mcrc_pkg::FRAG_1: dec_frag = 3'd1;
         mcrc_pkg::FRAG_2: dec_frag = 3'd2;
         mcrc_pkg::FRAG_3: dec_frag = 3'd3;
         default: dec_frag = mcrc_pkg::FRAG_INVALID;
      endcase
   end

   always_ff @(posedge rTXByteSent)
   begin
      if (reset_begin)
      begin
         state      <= ST_HUNT;
         pre_cnt    <= '0;
         skip       <= 1'b0;
         smd_valid  <= 1'b0;
         frag_valid <= 1'b0;
         check_done <= 1'b0;
         mcrc_ok    <= 1'b0;
      end
      else
      begin
         smd_valid  <= 1'b0;
         frag_valid <= 1'b0;
         check_done <= 1'b0;
         if (body.last)
         begin
            // only a packet with an accepted delimiter is checked.
            if (state == ST_FRAG || state == ST_BODY)
            begin
               check_done <= 1'b1;
               mcrc_ok    <= (tail.word == (mcrc ^ mcrc_pkg::MCRC_XOR));
            end
            state   <= ST_HUNT;
            pre_cnt <= '0;
            skip    <= 1'b0;
         end
         else if (body.strobe)
         begin
            // a new packet drops the old result.
            if (body.first)
            begin
               mcrc_ok <= 1'b0;
            end
            case (state)
               ST_HUNT:
               begin
                  if (!skip)
                  begin
                     if (body.octet != mcrc_pkg::PREAMBLE_OCTET)
                     begin
                        skip <= 1'b1;
                     end
                     else if (pre_cnt == CNT_W'(PREAMBLE_MIN - 1))
                     begin
                        state <= ST_SMD;
                     end
                     else
                     begin
                        pre_cnt <= pre_cnt + 1'b1;
                     end
                  end
               end
               ST_SMD:
               begin
                  // extra preamble octets are allowed before the delimiter.
                  if (body.octet != mcrc_pkg::PREAMBLE_OCTET)
                  begin
                     smd_valid <= 1'b1;
                     smd_kind  <= dec_kind;
                     frame_cnt <= dec_frame;
                     mcrc      <= mcrc_pkg::MCRC_INIT;
                     state     <= (dec_kind == mcrc_pkg::KIND_CONT) ? ST_FRAG : ST_BODY;
                  end
               end
               ST_FRAG:
               begin
                  // the fragment count octet is covered by the mcrc.
                  frag_valid <= 1'b1;
                  frag_cnt   <= dec_frag;
                  mcrc       <= mcrc_pkg::mcrc_octet(mcrc, body.octet);
                  state      <= ST_BODY;
               end
               default:
               begin
                  mcrc <= mcrc_pkg::mcrc_octet(mcrc, body.octet);
               end
            endcase
         end
      end
   end

endmodule

// ==== mac_merge_rx.sv ====
// receive top of the merge sublayer, joins deserializer, tail buffer and smd/mcrc checker.
module mac_merge_rx
#(
   parameter int PREAMBLE_MIN = 3
)
(
   input  logic                   rTXByteSent,
   input  logic                   reset_begin,
   input  logic                   rx_dv,
   input  logic                   rx_bit,
   output logic                   smd_valid,
   output mcrc_pkg::smd_kind_e    smd_kind,
   output mcrc_pkg::frame_cnt_t   frame_cnt,
   output logic                   frag_valid,
   output mcrc_pkg::frag_cnt_t    frag_cnt,
   output logic                   check_done,
   output logic                   mcrc_ok
);

   // deserializer to tail buffer.
   octet_if raw_octets ();

   // tail buffer to checker, mcrc field removed.
   octet_if body_octets ();

   // last four octets, valid with body_octets.last.
   mcrc_pkg::mcrc_tail_u tail;

   octet_deserializer u_deser
   (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .rx_dv       (rx_dv),
      .rx_bit      (rx_bit),
      .raw         (raw_octets)
   );

   mcrc_tail_buffer u_tail
   (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .in_octets   (raw_octets),
      .out_octets  (body_octets),
      .tail        (tail)
   );

   smd_mcrc_checker #(.PREAMBLE_MIN(PREAMBLE_MIN)) u_check
   (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .body        (body_octets),
      .tail        (tail),
      .smd_valid   (smd_valid),
      .smd_kind    (smd_kind),
      .frame_cnt   (frame_cnt),
      .frag_valid  (frag_valid),
      .frag_cnt    (frag_cnt),
      .check_done  (check_done),
      .mcrc_ok     (mcrc_ok)
   );

endmodule

// ==== tb_frames.svh ====
// frame table and payload lcg for the mac_merge_rx testbench, included inside its module.
`ifndef TB_FRAMES_SVH
`define TB_FRAMES_SVH

   // one stimulus row with its expected results.
   typedef struct
   {
      int                   pre_len;
      mcrc_pkg::octet_t     smd;
      bit                   has_frag;
      mcrc_pkg::octet_t     frag;
      int                   pay_len;
      bit                   corrupt;
      mcrc_pkg::smd_kind_e  exp_kind;
      mcrc_pkg::frame_cnt_t exp_frame;
      mcrc_pkg::frag_cnt_t  exp_frag;
      bit                   exp_smd;
      logic                 exp_ok;
   } row_t;

   localparam int NUM_ROWS = 16;

   row_t rows [NUM_ROWS];

   task automatic load_table();
      // pre, smd, has_frag, frag, payload, corrupt, kind, frame, frag_cnt, smd seen, mcrc_ok.
      rows[0]  = '{3, mcrc_pkg::SMD_E, 0, 8'h00, 6, 0, mcrc_pkg::KIND_EXPRESS, 2'd0, 3'd0, 1, 1};
      rows[1]  = '{3, mcrc_pkg::SMD_S0, 0, 8'h00, 5, 0, mcrc_pkg::KIND_START, 2'd0, 3'd0, 1, 1};
      rows[2]  = '{3, mcrc_pkg::SMD_S1, 0, 8'h00, 4, 0, mcrc_pkg::KIND_START, 2'd1, 3'd0, 1, 1};
      rows[3]  = '{3, mcrc_pkg::SMD_S2, 0, 8'h00, 7, 0, mcrc_pkg::KIND_START, 2'd2, 3'd0, 1, 1};
      rows[4]  = '{3, mcrc_pkg::SMD_S3, 0, 8'h00, 6, 0, mcrc_pkg::KIND_START, 2'd3, 3'd0, 1, 1};
      rows[5]  = '{3, mcrc_pkg::SMD_C0, 1, mcrc_pkg::FRAG_0, 5, 0,
                   mcrc_pkg::KIND_CONT, 2'd0, 3'd0, 1, 1};
      rows[6]  = '{3, mcrc_pkg::SMD_C1, 1, mcrc_pkg::FRAG_1, 4, 0,
                   mcrc_pkg::KIND_CONT, 2'd1, 3'd1, 1, 1};
      rows[7]  = '{3, mcrc_pkg::SMD_C2, 1, mcrc_pkg::FRAG_2, 6, 0,
                   mcrc_pkg::KIND_CONT, 2'd2, 3'd2, 1, 1};
      rows[8]  = '{3, mcrc_pkg::SMD_C3, 1, mcrc_pkg::FRAG_3, 5, 0,
                   mcrc_pkg::KIND_CONT, 2'd3, 3'd3, 1, 1};
      // unknown fragment code decodes as invalid.
      rows[9]  = '{3, mcrc_pkg::SMD_C0, 1, 8'h33, 4, 0,
                   mcrc_pkg::KIND_CONT, 2'd0, 3'd4, 1, 1};
      rows[10] = '{3, mcrc_pkg::SMD_E, 0, 8'h00, 6, 1, mcrc_pkg::KIND_EXPRESS, 2'd0, 3'd0, 1, 0};
      rows[11] = '{3, mcrc_pkg::SMD_V, 0, 8'h00, 4, 0, mcrc_pkg::KIND_VERIFY, 2'd0, 3'd0, 1, 1};
      rows[12] = '{3, mcrc_pkg::SMD_R, 0, 8'h00, 4, 0, mcrc_pkg::KIND_RESPOND, 2'd0, 3'd0, 1, 1};
      rows[13] = '{3, 8'hA5, 0, 8'h00, 5, 0, mcrc_pkg::KIND_ERROR, 2'd0, 3'd0, 1, 1};
      // short preamble, nothing may be reported.
      rows[14] = '{2, mcrc_pkg::SMD_E, 0, 8'h00, 5, 0, mcrc_pkg::KIND_EXPRESS, 2'd0, 3'd0, 0, 0};
      // longer preamble right after, must decode normally.
      rows[15] = '{4, mcrc_pkg::SMD_S1, 0, 8'h00, 5, 0, mcrc_pkg::KIND_START, 2'd1, 3'd0, 1, 1};
   endtask

   // next state of the payload lcg.
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

`endif

// ==== tb_mac_merge_rx.sv ====
// testbench for mac_merge_rx, sends the frame table as a serial stream and checks every result.
module tb_mac_merge_rx;

   // clock and dut inputs.
   logic rTXByteSent;
   logic reset_begin;
   logic rx_dv;
   logic rx_bit;

   // dut outputs.
   logic                 smd_valid;
   mcrc_pkg::smd_kind_e  smd_kind;
   mcrc_pkg::frame_cnt_t frame_cnt;
   logic                 frag_valid;
   mcrc_pkg::frag_cnt_t  frag_cnt;
   logic                 check_done;
   logic                 mcrc_ok;

   localparam int RESET_CYCLES = 5;
   // cycles allowed for check_done after rx_dv falls.
   localparam int DONE_WAIT    = 20;
   // idle gap between packets, at least three.
   localparam int IDLE_CYCLES  = 4;

   `include "tb_frames.svh"

   // pulses captured during the current row.
   logic                 got_smd;
   logic                 got_frag;
   logic                 got_done;
   mcrc_pkg::smd_kind_e  cap_kind;
   mcrc_pkg::frame_cnt_t cap_frame;
   mcrc_pkg::frag_cnt_t  cap_frag;
   logic                 cap_ok;
   // mcrc_ok as seen with the delimiter.
   logic                 cap_ok_smd;

   int               cycle_cnt = 0;
   int               cycle_limit = 0;
   int               row_err;
   int               pass_cnt = 0;
   int               fail_cnt = 0;
   logic [31:0]      lcg_state;
   mcrc_pkg::octet_t frame_q [$];

   mac_merge_rx #(.PREAMBLE_MIN(3)) uut
   (
      .rTXByteSent (rTXByteSent),
      .reset_begin (reset_begin),
      .rx_dv       (rx_dv),
      .rx_bit      (rx_bit),
      .smd_valid   (smd_valid),
      .smd_kind    (smd_kind),
      .frame_cnt   (frame_cnt),
      .frag_valid  (frag_valid),
      .frag_cnt    (frag_cnt),
      .check_done  (check_done),
      .mcrc_ok     (mcrc_ok)
   );

   initial
   begin
      rTXByteSent = 1'b0;
      forever #5 rTXByteSent = ~rTXByteSent;
   end

   // pulses are sampled on the falling edge, half a cycle after they change.
   always @(negedge rTXByteSent)
   begin
      if (smd_valid)
      begin
         got_smd    = 1'b1;
         cap_kind   = smd_kind;
         cap_frame  = frame_cnt;
         cap_ok_smd = mcrc_ok;
      end
      if (frag_valid)
      begin
         got_frag = 1'b1;
         cap_frag = frag_cnt;
      end
      if (check_done)
      begin
         got_done = 1'b1;
         cap_ok   = mcrc_ok;
      end
   end

   // run limit.
   always @(posedge rTXByteSent)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the frame table did not complete", cycle_cnt);
         $display("tests failed");
         $finish;
      end
   end

   task automatic check_kind(input mcrc_pkg::smd_kind_e got, input mcrc_pkg::smd_kind_e exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: smd_kind got %s expected %s", $time, got.name(), exp.name());
         row_err++;
      end
   endtask

   task automatic check_frame(input mcrc_pkg::frame_cnt_t got, input mcrc_pkg::frame_cnt_t exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: frame_cnt got %0d expected %0d", $time, got, exp);
         row_err++;
      end
   endtask

   task automatic check_frag(input mcrc_pkg::frag_cnt_t got, input mcrc_pkg::frag_cnt_t exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: frag_cnt got %0d expected %0d", $time, got, exp);
         row_err++;
      end
   endtask

   task automatic check_ok(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: mcrc_ok got %b expected %b", $time, got, exp);
         row_err++;
      end
   endtask

   // total serial bits of the table, for the run limit.
   function automatic int table_bits();
      int n;
      n = 0;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         n += (rows[i].pre_len + 1 + int'(rows[i].has_frag) + rows[i].pay_len + 4) * 8;
      end
      return n;
   endfunction

   // preamble, delimiter, fragment, payload, then the mcrc field msb octet first.
   task automatic build_frame(input row_t r);
      mcrc_pkg::mcrc_t  crc;
      mcrc_pkg::octet_t o;
      frame_q.delete();
      crc = mcrc_pkg::MCRC_INIT;
      for (int i = 0; i < r.pre_len; i++)
      begin
         frame_q.push_back(mcrc_pkg::PREAMBLE_OCTET);
      end
      frame_q.push_back(r.smd);
      if (r.has_frag)
      begin
         frame_q.push_back(r.frag);
         crc = mcrc_pkg::mcrc_octet(crc, r.frag);
      end
      for (int i = 0; i < r.pay_len; i++)
      begin
         lcg_state = lcg_next(lcg_state);
         o = lcg_state[23:16];
         frame_q.push_back(o);
         crc = mcrc_pkg::mcrc_octet(crc, o);
      end
      crc = crc ^ mcrc_pkg::MCRC_XOR;
      if (r.corrupt)
      begin
         crc[5] = ~crc[5];
      end
      frame_q.push_back(crc[31:24]);
      frame_q.push_back(crc[23:16]);
      frame_q.push_back(crc[15:8]);
      frame_q.push_back(crc[7:0]);
   endtask

   // one bit per clock, lsb first, then rx_dv drops.
   task automatic send_frame();
      foreach (frame_q[i])
      begin
         for (int b = 0; b < 8; b++)
         begin
            @(posedge rTXByteSent);
            rx_dv  <= 1'b1;
            rx_bit <= frame_q[i][b];
         end
      end
      @(posedge rTXByteSent);
      rx_dv  <= 1'b0;
      rx_bit <= 1'b0;
   endtask

   task automatic check_row(input int idx, input row_t r);
      if (r.exp_smd)
      begin
         if (!got_smd)
         begin
            $display("row %0d: smd_valid never pulsed", idx);
            row_err++;
         end
         else
         begin
            check_kind(cap_kind, r.exp_kind);
            // frame count only means something for start and continuation.
            if (r.exp_kind == mcrc_pkg::KIND_START || r.exp_kind == mcrc_pkg::KIND_CONT)
            begin
               check_frame(cap_frame, r.exp_frame);
            end
            // the previous result is gone once the packet has started.
            check_ok(cap_ok_smd, 1'b0);
         end
         if (r.has_frag && !got_frag)
         begin
            $display("row %0d: frag_valid never pulsed after the continuation delimiter", idx);
            row_err++;
         end
         else if (r.has_frag)
         begin
            check_frag(cap_frag, r.exp_frag);
         end
         if (!got_done)
         begin
            $display("row %0d: check_done never pulsed", idx);
            row_err++;
         end
         else
         begin
            check_ok(cap_ok, r.exp_ok);
         end
      end
      else if (got_smd || got_done)
      begin
         $display("row %0d: a packet with a short preamble was reported", idx);
         row_err++;
      end
      if (!r.has_frag && got_frag)
      begin
         $display("row %0d: frag_valid pulsed without a continuation delimiter", idx);
         row_err++;
      end
      // mcrc_ok keeps its level through the idle gap.
      check_ok(mcrc_ok, r.exp_ok);
   endtask

   initial
   begin
      reset_begin = 1'b1;
      rx_dv       = 1'b0;
      rx_bit      = 1'b0;
      lcg_state   = 32'h873;
      load_table();
      cycle_limit = RESET_CYCLES + 40 * NUM_ROWS + table_bits();
      repeat (RESET_CYCLES) @(posedge rTXByteSent);
      reset_begin <= 1'b0;
      repeat (IDLE_CYCLES) @(posedge rTXByteSent);
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         row_err  = 0;
         got_smd  = 1'b0;
         got_frag = 1'b0;
         got_done = 1'b0;
         build_frame(rows[i]);
         send_frame();
         // a short preamble row waits out the whole window.
         for (int w = 0; w < DONE_WAIT && !got_done; w++)
         begin
            @(posedge rTXByteSent);
         end
         repeat (IDLE_CYCLES) @(posedge rTXByteSent);
         check_row(i, rows[i]);
         if (row_err == 0)
         begin
            pass_cnt++;
            $display("row %0d: ok", i);
         end
         else
         begin
            fail_cnt++;
            $display("row %0d: %0d errors", i, row_err);
         end
      end
      $display("rows %0d, ok %0d, failing %0d", NUM_ROWS, pass_cnt, fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+.
mac_merge_pkg.sv
octet_if.sv
octet_deserializer.sv
mcrc_tail_buffer.sv
smd_mcrc_checker.sv
mac_merge_rx.sv
tb_mac_merge_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, and decide on the pass line in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module tb_mac_merge_rx -o sim_tb > sim.log 2>&1 &&
./obj_dir/sim_tb >> sim.log 2>&1 ||
{ cat sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^all tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
